// ==== src/fetch_pkg.sv ====
// ==========================================================
// Fetch front end shared definitions
// Address and parcel widths, queue and BTB sizing, PC steps
// and the two views of a fetched memory word
// ==========================================================

package fetch_pkg;

  // Address and data width
  localparam int XLEN = 32;

  // First fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // One RVC parcel is half a word
  localparam int PARCEL_W = 16;

  // Parcel queue sizing
  localparam int QUEUE_PARCELS = 4;
  localparam int QUEUE_CNT_W   = $clog2(QUEUE_PARCELS + 1);

  // ==========================================================
  // Branch target buffer geometry
  // ==========================================================
  // Index from PC[3:1], tag from PC[31:4]
  localparam int BTB_ENTRIES = 8;
  localparam int BTB_IDX_W   = 3;
  localparam int BTB_TAG_W   = 28;

  // PC steps after an issued instruction
  localparam logic [XLEN-1:0] PC_INC_C  = 2;
  localparam logic [XLEN-1:0] PC_INC_32 = 4;

  typedef logic [PARCEL_W-1:0] parcel_t;

  // Memory word, seen either whole or as two parcels
  // Low parcel sits at the lower halfword address
  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      parcel_t hi;
      parcel_t lo;
    } parcels;
  } fetch_word_t;

endpackage

// ==== src/pc_controller.sv ====
// ==========================================================
// Fetch address controller
// Steps the word fetch address, takes execute and predicted
// redirects, and tracks the response that is in flight
// ==========================================================

`timescale 1ns/100ps

module pc_controller (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_fetch_ready,
  input  logic                       i_ex_redirect,
  input  logic [fetch_pkg::XLEN-1:0] i_ex_target,
  input  logic                       i_pred_redirect,
  input  logic [fetch_pkg::XLEN-1:0] i_pred_target,
  output logic                       o_fetch_req,
  output logic [fetch_pkg::XLEN-1:0] o_fetch_addr,
  output logic                       o_resp_valid,
  output logic [fetch_pkg::XLEN-1:0] o_resp_addr,
  output logic                       o_resp_skip_lo
);

  import fetch_pkg::*;

  logic [XLEN-1:0] fetch_addr;
  logic [XLEN-1:0] redirect_target;
  logic            redirect;
  // Low until the first cycle out of reset
  logic            req_en;
  // Next request starts mid-word after a halfword target
  logic            skip_pending;

  // Execute has priority over the BTB
  assign redirect        = i_ex_redirect | i_pred_redirect;
  assign redirect_target = i_ex_redirect ? i_ex_target : i_pred_target;

  // Request whenever the aligner queue can absorb another word
  assign o_fetch_req  = req_en & i_fetch_ready;
  assign o_fetch_addr = fetch_addr;

  // ==========================================================
  // Fetch address and in-flight tracking
  // ==========================================================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fetch_addr   <= RESET_PC;
      skip_pending <= RESET_PC[1];
      req_en       <= 1'b0;
      o_resp_valid <= 1'b0;
    end else begin
      req_en <= 1'b1;
      if (redirect) begin
        // Fetch always word aligned, halfword offset kept as skip
        fetch_addr   <= {redirect_target[XLEN-1:2], 2'b00};
        skip_pending <= redirect_target[1];
      end else if (o_fetch_req) begin
        fetch_addr   <= fetch_addr + XLEN'(XLEN / 8);
        skip_pending <= 1'b0;
      end
      // A redirect kills whatever was requested this cycle
      o_resp_valid <= o_fetch_req & ~redirect;
    end
  end

  // Address and skip tag of the word now in flight
  always_ff @(posedge i_clk) begin
    if (o_fetch_req) begin
      o_resp_addr    <= fetch_addr;
      o_resp_skip_lo <= skip_pending;
    end
  end

endmodule

// ==== src/branch_target_buffer.sv ====
// ==========================================================
// Branch target buffer
// Direct mapped, looked up with the PC being issued and
// written by resolved branches from execute
// ==========================================================

`timescale 1ns/100ps

module branch_target_buffer (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic [fetch_pkg::XLEN-1:0] i_lookup_pc,
  input  logic                       i_update,
  input  logic [fetch_pkg::XLEN-1:0] i_update_pc,
  input  logic [fetch_pkg::XLEN-1:0] i_update_target,
  input  logic                       i_update_taken,
  output logic                       o_hit_taken,
  output logic [fetch_pkg::XLEN-1:0] o_hit_target
);

  import fetch_pkg::*;

  // Entry storage
  logic [BTB_ENTRIES-1:0] entry_valid;
  logic [BTB_ENTRIES-1:0] entry_taken;
  logic [BTB_TAG_W-1:0]   entry_tag [BTB_ENTRIES];
  logic [XLEN-1:0]        entry_target [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] lookup_idx;
  logic [BTB_TAG_W-1:0] lookup_tag;
  logic [BTB_IDX_W-1:0] update_idx;
  logic [BTB_TAG_W-1:0] update_tag;

  // ==========================================================
  // Index and tag split
  // ==========================================================
  // Bit 0 is always zero with RVC, so index starts at bit 1
  assign lookup_idx = i_lookup_pc[BTB_IDX_W:1];
  assign lookup_tag = i_lookup_pc[XLEN-1:BTB_IDX_W+1];
  assign update_idx = i_update_pc[BTB_IDX_W:1];
  assign update_tag = i_update_pc[XLEN-1:BTB_IDX_W+1];

  // Combinational lookup
  // Hit only on a valid matching entry that was last resolved taken
  assign o_hit_taken  = entry_valid[lookup_idx] &
                        entry_taken[lookup_idx] &
                        (entry_tag[lookup_idx] == lookup_tag);
  assign o_hit_target = entry_target[lookup_idx];

  // Valid bits cleared by reset
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      entry_valid <= '0;
    end else if (i_update) begin
      entry_valid[update_idx] <= 1'b1;
    end
  end

  // Entry payload
  // Not-taken updates overwrite too, which retires the prediction
  always_ff @(posedge i_clk) begin
    if (i_update) begin
      entry_tag[update_idx]    <= update_tag;
      entry_target[update_idx] <= i_update_target;
      entry_taken[update_idx]  <= i_update_taken;
    end
  end

endmodule

// ==== src/instruction_aligner.sv ====
// ==========================================================
// Instruction aligner
// Queues fetched parcels, finds instruction boundaries,
// assembles spanning 32-bit instructions and issues one
// instruction per cycle into the output register
// ==========================================================

`timescale 1ns/100ps

module instruction_aligner (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_stall,
  input  logic                       i_ex_redirect,
  input  logic                       i_resp_valid,
  input  logic [fetch_pkg::XLEN-1:0] i_resp_addr,
  input  logic                       i_resp_skip_lo,
  input  fetch_pkg::fetch_word_t     i_word,
  input  logic                       i_hit_taken,
  input  logic [fetch_pkg::XLEN-1:0] i_hit_target,
  output logic                       o_fetch_ready,
  output logic [fetch_pkg::XLEN-1:0] o_lookup_pc,
  output logic                       o_pred_redirect,
  output logic [fetch_pkg::XLEN-1:0] o_pred_target,
  output logic                       o_instr_valid,
  output logic [fetch_pkg::XLEN-1:0] o_instr,
  output logic [fetch_pkg::XLEN-1:0] o_instr_pc,
  output logic                       o_is_compressed,
  output logic                       o_pred_taken,
  output logic [fetch_pkg::XLEN-1:0] o_pred_target_out
);

  import fetch_pkg::*;

  // Parcel queue, entry 0 is the head
  parcel_t queue [QUEUE_PARCELS];
  parcel_t queue_next [QUEUE_PARCELS];
  logic [QUEUE_CNT_W-1:0] count;
  logic [QUEUE_CNT_W-1:0] count_next;
  logic [QUEUE_CNT_W-1:0] n_used;
  logic [QUEUE_CNT_W-1:0] n_in;
  logic [QUEUE_CNT_W-1:0] base;
  parcel_t in_first;

  // Head instruction state
  logic [XLEN-1:0] head_pc;
  logic            head_pc_ok;
  logic            head_is_c;
  logic            head_ready;
  logic [XLEN-1:0] head_instr;
  logic            issue_fire;
  logic            flush;

  // ==========================================================
  // Length detection and issue decision
  // ==========================================================
  // Low bits 11 mark a 32-bit encoding, anything else is RVC
  assign head_is_c  = (queue[0][1:0] != 2'b11);
  assign head_ready = head_is_c ? (count >= QUEUE_CNT_W'(1)) : (count >= QUEUE_CNT_W'(2));
  assign issue_fire = ~i_stall & ~i_ex_redirect & head_ready;
  // RVC zero-extended, 32-bit built from two parcels that may span words
  assign head_instr = head_is_c ? {{(XLEN-PARCEL_W){1'b0}}, queue[0]} : {queue[1], queue[0]};

  // BTB sees the head PC, prediction acts only when that head issues
  assign o_lookup_pc     = head_pc;
  assign o_pred_redirect = issue_fire & i_hit_taken;
  assign o_pred_target   = i_hit_target;
  assign flush           = i_ex_redirect | o_pred_redirect;

  // ==========================================================
  // Queue update
  // ==========================================================
  always_comb begin
    n_used   = issue_fire ? (head_is_c ? QUEUE_CNT_W'(1) : QUEUE_CNT_W'(2)) : '0;
    n_in     = i_resp_valid ? (i_resp_skip_lo ? QUEUE_CNT_W'(1) : QUEUE_CNT_W'(2)) : '0;
    // Skipped low parcel means the target was the high halfword
    in_first = i_resp_skip_lo ? i_word.parcels.hi : i_word.parcels.lo;
    base     = count - n_used;
    for (int i = 0; i < QUEUE_PARCELS; i++) begin
      queue_next[i] = queue[i];
      if (i < base) begin
        // Shift out what was issued
        queue_next[i] = queue[i + n_used];
      end else if (i == base) begin
        queue_next[i] = in_first;
      end else if (i == base + 1) begin
        queue_next[i] = i_word.parcels.hi;
      end
    end
    count_next = flush ? '0 : base + n_in;
  end

  // Room for one more word after this cycle's append and issue
  assign o_fetch_ready = (count_next <= QUEUE_CNT_W'(QUEUE_PARCELS - 2));

  always_ff @(posedge i_clk) begin
    queue <= queue_next;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count      <= '0;
      head_pc_ok <= 1'b0;
    end else begin
      count <= count_next;
      if (flush) begin
        head_pc_ok <= 1'b0;
      end else if (i_resp_valid) begin
        head_pc_ok <= 1'b1;
      end
    end
  end

  // Head PC, reloaded from the first word after a flush
  always_ff @(posedge i_clk) begin
    if (issue_fire) begin
      head_pc <= head_pc + (head_is_c ? PC_INC_C : PC_INC_32);
    end else if (!head_pc_ok && i_resp_valid && !flush) begin
      head_pc <= {i_resp_addr[XLEN-1:2], i_resp_skip_lo, 1'b0};
    end
  end

  // ==========================================================
  // Issue register
  // ==========================================================
  // Execute redirect clears valid even under stall
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_instr_valid <= 1'b0;
    end else if (i_ex_redirect) begin
      o_instr_valid <= 1'b0;
    end else if (!i_stall) begin
      o_instr_valid <= issue_fire;
    end
  end

  // Payload held while stalled or idle
  always_ff @(posedge i_clk) begin
    if (issue_fire) begin
      o_instr           <= head_instr;
      o_instr_pc        <= head_pc;
      o_is_compressed   <= head_is_c;
      o_pred_taken      <= i_hit_taken;
      o_pred_target_out <= i_hit_target;
    end
  end

endmodule

// ==== src/fetch_stage.sv ====
// ==========================================================
// Instruction fetch front end top level
// Connects the fetch address controller, the parcel aligner
// and the branch target buffer
// ==========================================================

`timescale 1ns/100ps

module fetch_stage (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_stall,
  input  logic                       i_ex_redirect,
  input  logic [fetch_pkg::XLEN-1:0] i_ex_target,
  input  logic                       i_btb_update,
  input  logic [fetch_pkg::XLEN-1:0] i_btb_update_pc,
  input  logic [fetch_pkg::XLEN-1:0] i_btb_update_target,
  input  logic                       i_btb_update_taken,
  input  fetch_pkg::fetch_word_t     i_instr,
  output logic                       o_fetch_req,
  output logic [fetch_pkg::XLEN-1:0] o_fetch_addr,
  output logic                       o_instr_valid,
  output logic [fetch_pkg::XLEN-1:0] o_instr,
  output logic [fetch_pkg::XLEN-1:0] o_instr_pc,
  output logic                       o_is_compressed,
  output logic                       o_pred_taken,
  output logic [fetch_pkg::XLEN-1:0] o_pred_target
);

  import fetch_pkg::*;

  // Aligner to PC controller
  logic            fetch_ready;
  logic            pred_redirect;
  logic [XLEN-1:0] pred_target;
  // Response tracking from PC controller
  logic            resp_valid;
  logic [XLEN-1:0] resp_addr;
  logic            resp_skip_lo;
  // BTB lookup
  logic [XLEN-1:0] lookup_pc;
  logic            hit_taken;
  logic [XLEN-1:0] hit_target;

  pc_controller u_pc_controller (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_fetch_ready   (fetch_ready),
    .i_ex_redirect   (i_ex_redirect),
    .i_ex_target     (i_ex_target),
    .i_pred_redirect (pred_redirect),
    .i_pred_target   (pred_target),
    .o_fetch_req     (o_fetch_req),
    .o_fetch_addr    (o_fetch_addr),
    .o_resp_valid    (resp_valid),
    .o_resp_addr     (resp_addr),
    .o_resp_skip_lo  (resp_skip_lo)
  );

  instruction_aligner u_instruction_aligner (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_stall           (i_stall),
    .i_ex_redirect     (i_ex_redirect),
    .i_resp_valid      (resp_valid),
    .i_resp_addr       (resp_addr),
    .i_resp_skip_lo    (resp_skip_lo),
    .i_word            (i_instr),
    .i_hit_taken       (hit_taken),
    .i_hit_target      (hit_target),
    .o_fetch_ready     (fetch_ready),
    .o_lookup_pc       (lookup_pc),
    .o_pred_redirect   (pred_redirect),
    .o_pred_target     (pred_target),
    .o_instr_valid     (o_instr_valid),
    .o_instr           (o_instr),
    .o_instr_pc        (o_instr_pc),
    .o_is_compressed   (o_is_compressed),
    .o_pred_taken      (o_pred_taken),
    .o_pred_target_out (o_pred_target)
  );

  // Update side driven straight from execute
  branch_target_buffer u_branch_target_buffer (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_lookup_pc     (lookup_pc),
    .i_update        (i_btb_update),
    .i_update_pc     (i_btb_update_pc),
    .i_update_target (i_btb_update_target),
    .i_update_taken  (i_btb_update_taken),
    .o_hit_taken     (hit_taken),
    .o_hit_target    (hit_target)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
// ==========================================================
// Testbench clock source
// Free running clock with a 4 ns period
// ==========================================================

`timescale 1ns/100ps

module tb_clock_gen (
  output logic o_clk
);

  // Half of the 4 ns period
  localparam int HALF_PERIOD_NS = 2;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
  end

endmodule

// ==== dv/tb_fetch_stage.sv ====
// ==========================================================
// Fetch stage testbench
// Word memory model, reference walker over the same memory,
// directed tests for alignment, redirects, stalls and BTB
// ==========================================================

`timescale 1ns/100ps

module tb_fetch_stage;

  import fetch_pkg::*;

  // Memory of 256 words indexed by address bits 9 to 2
  localparam int MEM_AW    = 8;
  localparam int MEM_WORDS = 1 << MEM_AW;
  localparam logic [31:0] LFSR_SEED = 32'h7ab9_5347;
  // Instructions checked per test
  localparam int N_STREAM = 40;
  localparam int N_MIXED  = 120;
  localparam int N_LEAD   = 12;
  localparam int N_REDIR  = 40;
  localparam int N_STALL  = 100;
  localparam int N_BTB    = 24;
  // Up to 8 cycles per instruction plus reset and redirect overhead
  localparam int TIMEOUT_CYCLES =
    8 * (N_STREAM + N_MIXED + N_LEAD + N_REDIR + N_STALL + 2 * N_BTB) + 400;

  logic            clk;
  logic            rst_n;
  logic            stall;
  logic            ex_redirect;
  logic [XLEN-1:0] ex_target;
  logic            btb_update;
  logic [XLEN-1:0] btb_update_pc;
  logic [XLEN-1:0] btb_update_target;
  logic            btb_update_taken;
  fetch_word_t     mem_rdata;
  logic            fetch_req;
  logic [XLEN-1:0] fetch_addr;
  logic            instr_valid;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] instr_pc;
  logic            is_compressed;
  logic            pred_taken;
  logic [XLEN-1:0] pred_target;

  fetch_word_t mem [MEM_WORDS];
  logic [31:0] lfsr_state;
  // BTB entry as the tests last wrote it
  logic            btb_valid_ref;
  logic            btb_taken_ref;
  logic [XLEN-1:0] btb_pc_ref;
  logic [XLEN-1:0] btb_target_ref;
  int error_count = 0;
  int test_errors = 0;
  int check_count = 0;
  int test_count  = 0;
  int span_count  = 0;
  int btb_visits  = 0;
  int cycle_count = 0;

  tb_clock_gen u_clock_gen (
    .o_clk (clk)
  );

  fetch_stage i_fetch_stage (
    .i_clk               (clk),
    .i_rst_n             (rst_n),
    .i_stall             (stall),
    .i_ex_redirect       (ex_redirect),
    .i_ex_target         (ex_target),
    .i_btb_update        (btb_update),
    .i_btb_update_pc     (btb_update_pc),
    .i_btb_update_target (btb_update_target),
    .i_btb_update_taken  (btb_update_taken),
    .i_instr             (mem_rdata),
    .o_fetch_req         (fetch_req),
    .o_fetch_addr        (fetch_addr),
    .o_instr_valid       (instr_valid),
    .o_instr             (instr),
    .o_instr_pc          (instr_pc),
    .o_is_compressed     (is_compressed),
    .o_pred_taken        (pred_taken),
    .o_pred_target       (pred_target)
  );

  // Synchronous memory with one cycle of read latency
  always @(posedge clk) begin
    if (fetch_req) begin
      mem_rdata <= mem[fetch_addr[MEM_AW+1:2]];
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ==========================================================
  // Stimulus helpers and reference walker
  // ==========================================================
  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One bit per step taken from the bit shifted out
  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    return b;
  endfunction

  // Parcel contents mix every address bit
  function automatic parcel_t addr_pattern(input logic [XLEN-1:0] addr);
    return addr[31:16] ^ addr[15:0] ^ {addr[7:0], addr[15:8]} ^ 16'hc3a5;
  endfunction

  function automatic parcel_t read_parcel(input logic [XLEN-1:0] addr);
    fetch_word_t w;
    w = mem[addr[MEM_AW+1:2]];
    return addr[1] ? w.parcels.hi : w.parcels.lo;
  endfunction

  function automatic void write_parcel(input logic [XLEN-1:0] addr, input parcel_t p);
    fetch_word_t w;
    w = mem[addr[MEM_AW+1:2]];
    if (addr[1]) begin
      w.parcels.hi = p;
    end else begin
      w.parcels.lo = p;
    end
    mem[addr[MEM_AW+1:2]] = w;
  endfunction

  // Low bits 11 mean a 32-bit encoding
  function automatic logic parcel_is_32(input parcel_t p);
    return p[1:0] == 2'b11;
  endfunction

  // PC after a number of instructions by the length rule alone
  function automatic logic [XLEN-1:0] walk_pc(input logic [XLEN-1:0] start, input int steps);
    logic [XLEN-1:0] pc;
    pc = start;
    for (int i = 0; i < steps; i++) begin
      pc = pc + (parcel_is_32(read_parcel(pc)) ? PC_INC_32 : PC_INC_C);
    end
    return pc;
  endfunction

  // First instruction on the walk at a halfword address or zero if none
  function automatic logic [XLEN-1:0] find_halfword_pc(input logic [XLEN-1:0] start,
                                                       input int min_steps);
    logic [XLEN-1:0] pc;
    pc = walk_pc(start, min_steps);
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (pc[1]) begin
        return pc;
      end
      pc = walk_pc(pc, 1);
    end
    return '0;
  endfunction

  // Every word a 32-bit instruction
  task automatic fill_stream_32();
    logic [XLEN-1:0] addr;
    for (int i = 0; i < MEM_WORDS; i++) begin
      addr = XLEN'(i * 4);
      mem[i].raw = {addr_pattern(addr + 2), addr_pattern(addr) | 16'h0003};
    end
  endtask

  // Random mix of lengths where 32-bit ones may straddle words
  task automatic fill_mixed();
    logic [XLEN-1:0] addr;
    addr = '0;
    while (addr < XLEN'(MEM_WORDS * 4)) begin
      if (take_bit() && addr < XLEN'(MEM_WORDS * 4 - 2)) begin
        write_parcel(addr, addr_pattern(addr) | 16'h0003);
        write_parcel(addr + 2, addr_pattern(addr + 2) ^ 16'h0f0f);
        addr = addr + 4;
      end else begin
        write_parcel(addr, addr_pattern(addr) & 16'hfffd);
        addr = addr + 2;
      end
    end
  endtask

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic finish_test(input string name, input int issued);
    test_count++;
    $display("[%0t] %s: %0d instructions, %0d errors, %s", $time, name, issued,
             test_errors, (test_errors == 0) ? "ok" : "FAIL");
    test_errors = 0;
  endtask

  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (7) @(posedge clk);
    // Nothing is requested or issued while reset is held
    @(negedge clk);
    check_count++;
    if (fetch_req !== 1'b0 || instr_valid !== 1'b0) begin
      report_error($sformatf("under reset o_fetch_req %b o_instr_valid %b, expected both low",
                             fetch_req, instr_valid));
    end
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // Valid drops and the target word goes out right after the redirect edge
  task automatic redirect_to(input logic [XLEN-1:0] target);
    @(posedge clk);
    ex_redirect <= 1'b1;
    ex_target   <= target;
    @(posedge clk);
    ex_redirect <= 1'b0;
    @(negedge clk);
    check_count++;
    if (instr_valid !== 1'b0) begin
      report_error($sformatf("o_instr_valid high in the cycle after redirect to %h", target));
    end
    if (fetch_addr !== (target & ~XLEN'(3))) begin
      report_error($sformatf("fetch address %h after redirect to %h, expected its word",
                             fetch_addr, target));
    end
  endtask

  task automatic btb_write(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target,
                           input logic taken);
    @(posedge clk);
    btb_update        <= 1'b1;
    btb_update_pc     <= pc;
    btb_update_target <= target;
    btb_update_taken  <= taken;
    @(posedge clk);
    btb_update     <= 1'b0;
    btb_valid_ref  = 1'b1;
    btb_pc_ref     = pc;
    btb_target_ref = target;
    btb_taken_ref  = taken;
  endtask

  // ==========================================================
  // Issue checker
  // ==========================================================
  // Consumes an instruction on each unstalled valid cycle at the falling edge
  task automatic check_stream(input logic [XLEN-1:0] start_pc, input int n_instr,
                              input logic use_stall);
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   exp_instr;
    parcel_t           first;
    logic              exp_c;
    logic              exp_pred;
    logic              prev_stall;
    logic [3*XLEN+2:0] held;
    int                got;
    pc         = start_pc;
    got        = 0;
    prev_stall = 1'b0;
    held       = '0;
    while (got < n_instr) begin
      @(posedge clk);
      if (use_stall) begin
        stall <= take_bit();
      end
      @(negedge clk);
      // A stall sampled at the last edge freezes the issue register
      if (prev_stall && held !== {instr_valid, instr, instr_pc, is_compressed,
                                  pred_taken, pred_target}) begin
        report_error("issue outputs changed while stalled");
      end
      held       = {instr_valid, instr, instr_pc, is_compressed, pred_taken, pred_target};
      prev_stall = stall;
      if (instr_valid && !stall) begin
        first     = read_parcel(pc);
        exp_c     = !parcel_is_32(first);
        exp_instr = exp_c ? {{(XLEN-PARCEL_W){1'b0}}, first} : {read_parcel(pc + 2), first};
        exp_pred  = btb_valid_ref && btb_taken_ref && (pc == btb_pc_ref);
        check_count++;
        if (instr_pc !== pc || instr !== exp_instr || is_compressed !== exp_c) begin
          report_error($sformatf("issue %0d pc %h instr %h c %b, expected pc %h instr %h c %b",
                                 got, instr_pc, instr, is_compressed, pc, exp_instr, exp_c));
        end
        if (pred_taken !== exp_pred || (exp_pred && pred_target !== btb_target_ref)) begin
          report_error($sformatf("pc %h prediction %b target %h, expected %b target %h",
                                 pc, pred_taken, pred_target, exp_pred, btb_target_ref));
        end
        // Spanning and branch visits as the DUT issued them
        if (!is_compressed && instr_pc[1]) begin
          span_count++;
        end
        if (btb_valid_ref && instr_pc == btb_pc_ref) begin
          btb_visits++;
        end
        pc  = exp_pred ? btb_target_ref : pc + (exp_c ? PC_INC_C : PC_INC_32);
        got = got + 1;
      end
    end
    if (use_stall) begin
      @(posedge clk);
      stall <= 1'b0;
    end
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic stream_32bit_test();
    fill_stream_32();
    apply_reset();
    check_stream(RESET_PC, N_STREAM, 1'b0);
    finish_test("stream_32bit", N_STREAM);
  endtask

  task automatic mixed_lengths_test();
    fill_mixed();
    span_count = 0;
    redirect_to(RESET_PC);
    check_stream(RESET_PC, N_MIXED, 1'b0);
    check_count++;
    if (span_count == 0) begin
      report_error("no word-spanning 32-bit instruction was issued");
    end
    finish_test("mixed_lengths", N_MIXED);
  endtask

  task automatic ex_redirect_test();
    logic [XLEN-1:0] target;
    fill_mixed();
    redirect_to(RESET_PC);
    check_stream(RESET_PC, N_LEAD, 1'b0);
    target = find_halfword_pc(RESET_PC, 20);
    if (target[1] !== 1'b1) begin
      $display("No instruction at a halfword address was found for the redirect target");
      error_count++;
      test_errors++;
    end else begin
      redirect_to(target);
      check_stream(target, N_REDIR, 1'b0);
    end
    finish_test("ex_redirect", N_LEAD + N_REDIR);
  endtask

  task automatic random_stall_test();
    fill_mixed();
    redirect_to(RESET_PC);
    check_stream(RESET_PC, N_STALL, 1'b1);
    finish_test("random_stall", N_STALL);
  endtask

  // Taken entry redirects at the branch and a not-taken rewrite retires it
  task automatic btb_prediction_test();
    logic [XLEN-1:0] branch_pc;
    logic [XLEN-1:0] target;
    fill_mixed();
    branch_pc = walk_pc(RESET_PC, 8);
    target    = walk_pc(RESET_PC, 30);
    for (int pass = 0; pass < 2; pass++) begin
      btb_write(branch_pc, target, (pass == 0));
      btb_visits = 0;
      redirect_to(RESET_PC);
      check_stream(RESET_PC, N_BTB, 1'b0);
      check_count++;
      if (btb_visits != 1) begin
        report_error($sformatf("branch pc %h issued %0d times, expected once",
                               branch_pc, btb_visits));
      end
    end
    finish_test("btb_prediction", 2 * N_BTB);
  endtask

  initial begin
    rst_n             = 1'b0;
    stall             = 1'b0;
    ex_redirect       = 1'b0;
    ex_target         = '0;
    btb_update        = 1'b0;
    btb_update_pc     = '0;
    btb_update_target = '0;
    btb_update_taken  = 1'b0;
    mem_rdata         = '0;
    lfsr_state        = LFSR_SEED;
    btb_valid_ref     = 1'b0;
    btb_taken_ref     = 1'b0;
    btb_pc_ref        = '0;
    btb_target_ref    = '0;
    stream_32bit_test();
    mixed_lengths_test();
    ex_redirect_test();
    random_stall_test();
    btb_prediction_test();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
src/fetch_pkg.sv
src/pc_controller.sv
src/branch_target_buffer.sv
src/instruction_aligner.sv
src/fetch_stage.sv
dv/tb_clock_gen.sv
dv/tb_fetch_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator, run it, and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module tb_fetch_stage \
  -f filelist.f \
  -o sim_fetch_stage

./obj_dir/sim_fetch_stage 2>&1 | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
echo "Simulation passed, log in $LOG"
